// ==== compile.f ====
common/rv32Pkg.sv
rtl/instDecode.sv
rtl/regFile.sv
execute/aluUnit.sv
execute/branchUnit.sv
rtl/pcControl.sv
rtl/rv32Core.sv
+incdir+verification
verification/coreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -f compile.f --top-module coreTb -o coreTbSim || exit 1

./obj_dir/coreTbSim > sim.log 2>&1 || echo "simulator returned an error" >> sim.log

cat sim.log
! grep -q "sim failed" sim.log && grep -q "sim passed" sim.log && echo "PASS" || {
    echo "FAIL"
    exit 1
}

// ==== verification/tbIsa.svh ====
`ifndef TB_ISA_SVH
`define TB_ISA_SVH

// fibonacci lfsr, taps 32 22 2 1
function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
endfunction

function automatic word_t randBits(input int n);
    word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsrBit()};
    end
    return r;
endfunction

function automatic word_t encI(input word_t imm, rs1, f3, rd, op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic word_t encR(input word_t f7, rs2, rs1, f3, rd, op);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic word_t encS(input word_t imm, rs2, rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3Word, imm[4:0], opStore};
endfunction

function automatic word_t encB(input word_t imm, rs2, rs1, f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opBranch};
endfunction

function automatic word_t encU(input word_t imm, rd, op);
    return {imm[31:12], rd[4:0], op[6:0]};
endfunction

function automatic word_t encJ(input word_t imm, rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
endfunction

// one random instruction at word index idx, targets stay forward
function automatic word_t genInst(input int idx);
    word_t sel;
    word_t rd;
    word_t rs1;
    word_t rs2;
    word_t f3;
    word_t imm;
    word_t f7;
    word_t k;
    if (idx < 31) begin
        return encI(randBits(12), 0, word_t'(f3Add), word_t'(idx + 1), word_t'(opImm));
    end
    if (idx == 31) begin
        return encU(randBits(32) | 32'h8000_0000, 0, word_t'(opLui));  // nonzero into x0
    end
    if (idx == 32) begin
        return encS(randBits(6) << 2, 0, 0);  // store of x0 right after
    end
    sel = randBits(4);
    rd  = randBits(5);  // x0 included on purpose
    rs1 = randBits(5);
    rs2 = randBits(5);
    f3  = randBits(3);
    imm = randBits(12);
    k   = 1 + randBits(8) % word_t'(progLen - idx);
    if (sel < 4) begin
        if (f3[2:0] == f3Sll) begin
            imm[11:5] = '0;
        end else if (f3[2:0] == f3Sr) begin
            imm[11:5] = randBits(1) != 0 ? f7Alt : 7'b0;
        end
        return encI(imm, rs1, f3, rd, word_t'(opImm));
    end else if (sel < 7) begin
        f7 = ((f3[2:0] == f3Add || f3[2:0] == f3Sr) && randBits(1) != 0) ? word_t'(f7Alt) : 0;
        return encR(f7, rs2, rs1, f3, rd, word_t'(opReg));
    end else if (sel == 7) begin
        return encU(randBits(32), rd, word_t'(opLui));
    end else if (sel == 8) begin
        return encU(randBits(32), rd, word_t'(opAuipc));
    end else if (sel < 11) begin
        return encI(randBits(6) << 2, 0, word_t'(f3Word), rd, word_t'(opLoad));
    end else if (sel < 13) begin
        return encS(randBits(6) << 2, rs2, 0);
    end else if (sel == 13) begin
        f3 = randBits(3) % 6;
        f3 = (f3 < 2) ? f3 : f3 + 2;  // skip the reserved codes 2 and 3
        return encB(k << 2, rs2, rs1, f3);
    end else if (sel == 14) begin
        return encJ(k << 2, rd);
    end
    return encI((word_t'(idx) + k) << 2, 0, 0, rd, word_t'(opJalr));  // absolute target
endfunction

function automatic word_t aluRef(input logic [2:0] f3, input logic [6:0] f7,
                                 input word_t a, input word_t b, input logic isReg);
    case (f3)
        f3Add:   return (isReg && f7 == f7Alt) ? a - b : a + b;
        f3Sll:   return a << b[4:0];
        f3Slt:   return ($signed(a) < $signed(b)) ? 1 : 0;
        f3Sltu:  return (a < b) ? 1 : 0;
        f3Xor:   return a ^ b;
        f3Sr:    return (f7 == f7Alt) ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        f3Or:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branchRef(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        f3Beq:   return a == b;
        f3Bne:   return a != b;
        f3Blt:   return $signed(a) < $signed(b);
        f3Bge:   return $signed(a) >= $signed(b);
        f3Bltu:  return a < b;
        default: return a >= b;
    endcase
endfunction

// advance the shadow state by one instruction
task automatic stepShadow(output logic expWrite, output word_t expAddr, output word_t expData);
    word_t inst;
    word_t a;
    word_t b;
    word_t immI;
    word_t immS;
    word_t nextPc;
    word_t wr;
    logic  writesRd;
    expWrite = 1'b0;
    expAddr  = '0;
    expData  = '0;
    if (shadowHalt) begin
        return;
    end
    inst     = imem[shadowPc[9:2]];
    a        = shadowRegs[inst[19:15]];
    b        = shadowRegs[inst[24:20]];
    immI     = {{20{inst[31]}}, inst[31:20]};
    immS     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    nextPc   = shadowPc + 4;
    wr       = '0;
    writesRd = 1'b1;
    case (inst[6:0])
        opLui:   wr = {inst[31:12], 12'b0};
        opAuipc: wr = shadowPc + {inst[31:12], 12'b0};
        opJal: begin
            wr     = shadowPc + 4;
            nextPc = shadowPc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                 inst[30:21], 1'b0};
        end
        opJalr: begin
            wr     = shadowPc + 4;
            nextPc = (a + immI) & ~word_t'(1);
        end
        opBranch: begin
            writesRd = 1'b0;
            if (branchRef(inst[14:12], a, b)) begin
                nextPc = shadowPc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                     inst[11:8], 1'b0};
            end
        end
        opLoad:  wr = shadowMem[(a + immI) >> 2 & 63];
        opStore: begin
            writesRd = 1'b0;
            expWrite = 1'b1;
            expAddr  = a + immS;
            expData  = b;
            shadowMem[expAddr[7:2]] = b;
        end
        opImm:   wr = aluRef(inst[14:12], inst[31:25], a, immI, 1'b0);
        opReg:   wr = aluRef(inst[14:12], inst[31:25], a, b, 1'b1);
        default: begin
            shadowHalt = 1'b1;  // illegal word, pc stays
            return;
        end
    endcase
    if (writesRd && inst[11:7] != 5'd0) begin
        shadowRegs[inst[11:7]] = wr;
    end
    shadowPc = nextPc;
endtask

`endif

// ==== verification/coreTb.sv ====
`default_nettype none

module coreTb;
    import rv32Pkg::*;

    localparam int progLen     = 240;
    localparam int resetCycles = 8;
    localparam int margin      = 51;
    localparam int cycleLimit  = resetCycles + progLen + 1 + margin;

    logic     clk;
    logic     rst;
    word_t    instAddr;
    word_t    instWord;
    dataReq_t dataReq;
    word_t    dataRdata;
    logic     halt;

    word_t    imem [0:255];
    word_t    dmem [0:63];
    word_t    shadowMem [0:63];
    word_t    shadowRegs [0:31];
    word_t    shadowPc;
    logic     shadowHalt;
    word_t    lfsrState;
    int       cycles;
    int       errors;
    int       checks;
    logic     expWrite;
    word_t    expAddr;
    word_t    expData;

    `include "tbIsa.svh"

    rv32Core dut0 (
        .clk(clk), .rst(rst), .instAddr(instAddr), .instWord(instWord),
        .dataReq(dataReq), .dataRdata(dataRdata), .halt(halt)
    );

    task automatic checkEq(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memory models, driven while clk is low
    always @(negedge clk) begin
        if (cycles < resetCycles) begin
            instWord <= encS(32'h4, 0, 0);  // a store the reset has to mask
        end else begin
            instWord <= imem[instAddr[9:2]];
        end
        #2;
        dataRdata <= dmem[dataReq.addr[7:2]];  // address settles after the fetch
    end

    always @(posedge clk) begin
        cycles++;
        if (!rst) begin
            if (cycles > 1) begin
                checkEq("reset pc", resetPc, instAddr);
                checkEq("reset halt", 0, word_t'(halt));
                checkEq("reset write", 0, word_t'(dataReq.write));
            end
        end else begin
            checkEq("pc", shadowPc, instAddr);
            checkEq("halt", word_t'(shadowHalt), word_t'(halt));
            stepShadow(expWrite, expAddr, expData);
            checkEq("store strobe", word_t'(expWrite), word_t'(dataReq.write));
            if (expWrite) begin
                checkEq("store addr", expAddr, dataReq.addr);
                checkEq("store data", expData, dataReq.wdata);
            end
            if (dataReq.write && instWord[24:20] == 5'd0) begin
                checkEq("x0 store", '0, dataReq.wdata);
            end
            if (dataReq.write) begin
                dmem[dataReq.addr[7:2]] = dataReq.wdata;
            end
        end
    end

    initial begin
        rst       = 1'b0;
        instWord  = '0;
        dataRdata = '0;
        cycles    = 0;
        errors    = 0;
        checks    = 0;
        lfsrState = 32'h3427c251;
        shadowPc   = resetPc;
        shadowHalt = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadowRegs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i]      = randBits(32);
            shadowMem[i] = dmem[i];
        end
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < progLen) ? genInst(i) : 32'h0000007f;  // illegal opcode tail
        end

        repeat (resetCycles) @(negedge clk);
        rst = 1'b1;

        while (!halt && cycles < cycleLimit) begin
            @(negedge clk);
        end
        if (!halt) begin
            errors++;
            $display("the core never halted before the cycle limit");
        end else begin
            repeat (4) @(negedge clk);  // halted core must stay put
        end

        for (int i = 0; i < 64; i++) begin
            checkEq("data memory", shadowMem[i], dmem[i]);
        end

        $display("errors %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/rv32Core.sv ====
`default_nettype none

module rv32Core (
    input  logic              clk,
    input  logic              rst,
    output rv32Pkg::word_t    instAddr,
    input  rv32Pkg::word_t    instWord,
    output rv32Pkg::dataReq_t dataReq,
    input  rv32Pkg::word_t    dataRdata,
    output logic              halt
);
    import rv32Pkg::*;

    decoded_t dec;
    word_t    pc;
    word_t    nextPc;
    word_t    rs1Data;
    word_t    rs2Data;
    word_t    aluResult;
    word_t    wbData;
    word_t    effAddr;
    logic     aluIllegal;
    logic     branchIllegal;
    logic     misaligned;
    logic     fault;
    logic     writesRd;
    logic     regWrEn;

    assign instAddr = pc;

    instDecode decodeInst (.instWord(instWord), .dec(dec));

    regFile regs (
        .clk(clk), .rs1Addr(dec.rs1), .rs2Addr(dec.rs2), .rs1Data(rs1Data),
        .rs2Data(rs2Data), .wrEn(regWrEn), .wrAddr(dec.rd), .wrData(wbData)
    );

    aluUnit alu (
        .dec(dec), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .aluResult(aluResult), .aluIllegal(aluIllegal)
    );

    branchUnit branch (
        .dec(dec), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .nextPc(nextPc), .branchIllegal(branchIllegal)
    );

    pcControl pcCtrl (
        .clk(clk), .rst(rst), .nextPc(nextPc), .fault(fault), .pc(pc), .halt(halt)
    );

    assign effAddr    = rs1Data + dec.imm;  // imm is I or S by format
    assign misaligned = (dec.isLoad || dec.isStore) && (effAddr[1:0] != 2'b00);
    assign fault      = dec.illegal || aluIllegal || branchIllegal || misaligned;

    // write-back priority: upper imm, link, load, alu
    always_comb begin
        if (dec.isLui) begin
            wbData = dec.imm;
        end else if (dec.isAuipc) begin
            wbData = pc + dec.imm;
        end else if (dec.isJal || dec.isJalr) begin
            wbData = pc + word_t'(4);
        end else if (dec.isLoad) begin
            wbData = dataRdata;
        end else begin
            wbData = aluResult;
        end
    end

    assign writesRd = dec.isLui || dec.isAuipc || dec.isJal || dec.isJalr || dec.isLoad
                      || dec.isImm || dec.isReg;
    assign regWrEn  = writesRd && !halt && !fault && rst;

    always_comb begin
        dataReq.addr  = effAddr;
        dataReq.wdata = rs2Data;
        dataReq.write = dec.isStore && !halt && !fault && rst;  // faulting store dropped
    end

    // a fault halts the core and no store escapes afterwards
    noStoreAfterFault: assert property (
        @(posedge clk) disable iff (!rst) (fault || halt) |=> (halt && !dataReq.write)
    ) else $error("store issued while halted");

endmodule

`default_nettype wire

// ==== rtl/pcControl.sv ====
`default_nettype none

module pcControl (
    input  logic           clk,
    input  logic           rst,
    input  rv32Pkg::word_t nextPc,
    input  logic           fault,
    output rv32Pkg::word_t pc,
    output logic           halt
);
    import rv32Pkg::*;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc   <= resetPc;
            halt <= 1'b0;
        end else if (!halt) begin
            if (fault) begin
                halt <= 1'b1;  // pc stays on the faulting word
            end else begin
                pc <= nextPc;
            end
        end
    end

    // once halted nothing moves until reset
    pcHoldsOnHalt: assert property (
        @(posedge clk) disable iff (!rst) halt |=> ($stable(pc) && halt)
    ) else $error("pc moved while halted");

endmodule

`default_nettype wire

// ==== execute/branchUnit.sv ====
`default_nettype none

module branchUnit (
    input  rv32Pkg::decoded_t dec,
    input  rv32Pkg::word_t    pc,
    input  rv32Pkg::word_t    rs1Data,
    input  rv32Pkg::word_t    rs2Data,
    output rv32Pkg::word_t    nextPc,
    output logic              branchIllegal
);
    import rv32Pkg::*;

    logic  signedLt;
    logic  taken;
    logic  redirect;
    word_t jalrSum;
    word_t target;
    word_t seqPc;

    assign signedLt = $signed(rs1Data) < $signed(rs2Data);

    always_comb begin
        case (dec.funct3)
            f3Beq:   taken = rs1Data == rs2Data;
            f3Bne:   taken = rs1Data != rs2Data;
            f3Blt:   taken = signedLt;
            f3Bge:   taken = !signedLt;
            f3Bltu:  taken = rs1Data < rs2Data;
            f3Bgeu:  taken = rs1Data >= rs2Data;
            default: taken = 1'b0;  // decode flags 2 and 3
        endcase
    end

    assign seqPc   = pc + word_t'(4);
    assign jalrSum = rs1Data + dec.imm;
    assign target  = dec.isJalr ? {jalrSum[xlen-1:1], 1'b0} : (pc + dec.imm);

    assign redirect = dec.isJal || dec.isJalr || (dec.isBranch && taken);
    assign nextPc   = redirect ? target : seqPc;

    // only a target actually taken can fault
    assign branchIllegal = redirect && (target[1:0] != 2'b00);

endmodule

`default_nettype wire

// ==== execute/aluUnit.sv ====
`default_nettype none

module aluUnit (
    input  rv32Pkg::decoded_t dec,
    input  rv32Pkg::word_t    rs1Data,
    input  rv32Pkg::word_t    rs2Data,
    output rv32Pkg::word_t    aluResult,
    output logic              aluIllegal
);
    import rv32Pkg::*;

    word_t      opB;
    logic [4:0] shamt;
    logic       signedLt;
    logic       unsignedLt;
    word_t      sraResult;
    logic       f7Zero;
    logic       f7IsAlt;

    assign opB   = dec.isReg ? rs2Data : dec.imm;  // register or immediate form
    assign shamt = opB[4:0];

    assign signedLt   = $signed(rs1Data) < $signed(opB);
    assign unsignedLt = rs1Data < opB;  // sltiu compares against sign-extended imm
    assign sraResult  = word_t'($signed(rs1Data) >>> shamt);

    assign f7Zero  = dec.funct7 == 7'b0000000;
    assign f7IsAlt = dec.funct7 == f7Alt;

    always_comb begin
        case (dec.funct3)
            f3Add: begin
                if (dec.isReg && f7IsAlt) begin
                    aluResult = rs1Data - opB;  // sub
                end else begin
                    aluResult = rs1Data + opB;
                end
            end
            f3Sll:  aluResult = rs1Data << shamt;
            f3Slt:  aluResult = {{(xlen-1){1'b0}}, signedLt};
            f3Sltu: aluResult = {{(xlen-1){1'b0}}, unsignedLt};
            f3Xor:  aluResult = rs1Data ^ opB;
            f3Sr:   aluResult = f7IsAlt ? sraResult : (rs1Data >> shamt);
            f3Or:   aluResult = rs1Data | opB;
            f3And:  aluResult = rs1Data & opB;
        endcase
    end

    // reserved funct7 / upper immediate bits
    always_comb begin
        aluIllegal = 1'b0;
        if (dec.isImm) begin
            if (dec.funct3 == f3Sll) begin
                aluIllegal = !f7Zero;
            end else if (dec.funct3 == f3Sr) begin
                aluIllegal = !(f7Zero || f7IsAlt);
            end
        end else if (dec.isReg) begin
            if (dec.funct3 == f3Add || dec.funct3 == f3Sr) begin
                aluIllegal = !(f7Zero || f7IsAlt);  // add/sub, srl/sra
            end else begin
                aluIllegal = !f7Zero;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`default_nettype none

module regFile (
    input  logic               clk,
    input  rv32Pkg::regAddr_t  rs1Addr,
    input  rv32Pkg::regAddr_t  rs2Addr,
    output rv32Pkg::word_t     rs1Data,
    output rv32Pkg::word_t     rs2Data,
    input  logic               wrEn,
    input  rv32Pkg::regAddr_t  wrAddr,
    input  rv32Pkg::word_t     wrData
);
    import rv32Pkg::*;

    word_t regs [1:31];  // x0 has no storage

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

    always_ff @(posedge clk) begin
        if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;  // writes to x0 dropped
        end
    end

    // a write aimed at x0 must not leak into later reads
    x0StaysZero: assert property (
        @(posedge clk) (wrEn && wrAddr == '0) |=> (rs1Addr != '0 || rs1Data == '0)
    ) else $error("x0 read back nonzero after a write to x0");

endmodule

`default_nettype wire

// ==== rtl/instDecode.sv ====
`default_nettype none

module instDecode (
    input  rv32Pkg::word_t    instWord,
    output rv32Pkg::decoded_t dec
);
    import rv32Pkg::*;

    word_t immI;
    word_t immS;
    word_t immB;
    word_t immU;
    word_t immJ;
    logic  knownOp;
    logic  badJalr;
    logic  badMem;
    logic  badBranch;

    // the five immediate formats
    assign immI = {{20{instWord[31]}}, instWord[31:20]};
    assign immS = {{20{instWord[31]}}, instWord[31:25], instWord[11:7]};
    assign immB = {{19{instWord[31]}}, instWord[31], instWord[7],
                   instWord[30:25], instWord[11:8], 1'b0};
    assign immU = {instWord[31:12], 12'b0};
    assign immJ = {{11{instWord[31]}}, instWord[31], instWord[19:12],
                   instWord[20], instWord[30:21], 1'b0};

    always_comb begin
        dec.opcode = instWord[6:0];
        dec.funct3 = instWord[14:12];
        dec.funct7 = instWord[31:25];  // also imm[11:5] for shifts
        dec.rs1    = instWord[19:15];
        dec.rs2    = instWord[24:20];
        dec.rd     = instWord[11:7];

        dec.isLui    = dec.opcode == opLui;
        dec.isAuipc  = dec.opcode == opAuipc;
        dec.isJal    = dec.opcode == opJal;
        dec.isJalr   = dec.opcode == opJalr;
        dec.isBranch = dec.opcode == opBranch;
        dec.isLoad   = dec.opcode == opLoad;
        dec.isStore  = dec.opcode == opStore;
        dec.isImm    = dec.opcode == opImm;
        dec.isReg    = dec.opcode == opReg;

        // pick the immediate matching the format
        if (dec.isStore) begin
            dec.imm = immS;
        end else if (dec.isBranch) begin
            dec.imm = immB;
        end else if (dec.isLui || dec.isAuipc) begin
            dec.imm = immU;
        end else if (dec.isJal) begin
            dec.imm = immJ;
        end else begin
            dec.imm = immI;  // imm, load, jalr; unused for reg ops
        end

        knownOp = dec.isLui || dec.isAuipc || dec.isJal || dec.isJalr || dec.isBranch
                  || dec.isLoad || dec.isStore || dec.isImm || dec.isReg;
        badJalr   = dec.isJalr && (dec.funct3 != 3'b000);
        badMem    = (dec.isLoad || dec.isStore) && (dec.funct3 != f3Word);
        badBranch = dec.isBranch && (dec.funct3 inside {3'b010, 3'b011});

        // funct7 checks for arithmetic live in aluUnit
        dec.illegal = !knownOp || badJalr || badMem || badBranch;
    end

endmodule

`default_nettype wire

// ==== common/rv32Pkg.sv ====
`default_nettype none

package rv32Pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      regAddr_t;

    localparam word_t resetPc = '0;  // first fetch address

    // major opcodes
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;

    // arithmetic funct3
    localparam logic [2:0] f3Add  = 3'b000;
    localparam logic [2:0] f3Sll  = 3'b001;
    localparam logic [2:0] f3Slt  = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor  = 3'b100;
    localparam logic [2:0] f3Sr   = 3'b101;  // srl and sra share it
    localparam logic [2:0] f3Or   = 3'b110;
    localparam logic [2:0] f3And  = 3'b111;

    localparam logic [2:0] f3Word = 3'b010;  // lw / sw only

    // branch funct3
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    localparam logic [6:0] f7Alt = 7'b0100000;  // sub, sra, srai

    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        regAddr_t   rs1;
        regAddr_t   rs2;
        regAddr_t   rd;
        word_t      imm;       // sign extended for the format
        logic       illegal;
        logic       isLui;
        logic       isAuipc;
        logic       isJal;
        logic       isJalr;
        logic       isBranch;
        logic       isLoad;
        logic       isStore;
        logic       isImm;
        logic       isReg;
    } decoded_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;  // store commits at the rising edge
    } dataReq_t;

endpackage

`default_nettype wire
